// File: Makefile
# Verilator simulation of the posit multiplier testbench

VERILATOR ?= verilator
TOP       ?= posit_mul_unit_tb
FILELIST  ?= posit_mul_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: posit_mul_unit.f
+incdir+source
source/posit_fmt_pkg.sv
source/posit_pipe_pkg.sv
source/posit_fields_if.sv
source/delay_line.sv
source/posit_decompose_reg.sv
source/posit_multiply.sv
source/posit_mul_unit.sv
test/posit_mul_unit_checker.sv
test/posit_mul_unit_tb.sv

// File: source/delay_line.sv
// ==================================================
// Shift register advancing only on ce
// DEPTH must be at least 1
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int WIDTH = 1,
  parameter int DEPTH = 1
) (
  input  wire              clk,
  input  wire              ce,
  input  wire [WIDTH-1:0]  i,
  output logic [WIDTH-1:0] o
);

  // One register per delay step
  logic [WIDTH-1:0] stage_q [DEPTH];

  always_ff @(posedge clk) begin
    if (ce) begin
      stage_q[0] <= i;
      // Everything moves one step together
      for (int n = 1; n < DEPTH; n++) begin
        stage_q[n] <= stage_q[n-1];
      end
    end
  end

  // Oldest entry leaves the chain
  assign o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: source/posit_decompose_reg.sv
// ==================================================
// Splits a posit into fields, one enabled cycle
// Fields are undefined for zero and NaR inputs
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "posit_defines.svh"

module posit_decompose_reg (
  input  wire                        clk,
  input  wire                        ce,
  input  wire posit_fmt_pkg::posit_t i,
  posit_fields_if.decoder            f
);

  localparam int N  = `POSIT_WIDTH;
  localparam int ES = `POSIT_ES;
  localparam int RS = `POSIT_RS;

  posit_fmt_pkg::posit_t  mag;
  logic                   rgs;
  posit_fmt_pkg::regime_t run;
  logic                   run_done;
  logic [RS:0]            skip;
  logic [N-2:0]           rest;

  // ==================================================
  // Magnitude and regime
  // ==================================================

  // Negative posits decode from their two's complement
  assign mag = i[N-1] ? -i : i;

  // First body bit sets the regime polarity
  assign rgs = mag[N-2];

  // Count the run of bits equal to the first body bit
  always_comb begin
    run      = '0;
    run_done = 1'b0;
    for (int j = N - 2; j >= 0; j--) begin
      if (!run_done && (mag[j] == rgs)) begin
        run = run + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  // ==================================================
  // Exponent and significand
  // ==================================================

  // Drop the run and its terminating bit
  assign skip = {1'b0, run} + 1'b1;
  assign rest = mag[N-2:0] << skip;

  always_ff @(posedge clk) begin
    if (ce) begin
      f.sgn <= i[N-1];
      f.rgs <= rgs;
      // Run of ones encodes run-1, run of zeros encodes -run
      f.rgm <= rgs ? run - 1'b1 : run;
      f.exp <= rest[N-2 -: ES];
      // Hidden bit is always one for a normal posit
      f.sig <= {1'b1, rest[N-2-ES:0]};
      f.zer <= (i == '0);
      // NaR is sign bit alone
      f.inf <= (i == {1'b1, {(N-1){1'b0}}});
    end
  end

endmodule

`default_nettype wire

// File: source/posit_defines.svh
// ==================================================
// Posit format and multiplier pipeline constants
// POSIT_ES must be at least 1 for the field types
// ==================================================
`ifndef POSIT_DEFINES_SVH
`define POSIT_DEFINES_SVH

// Posit word width in bits
`define POSIT_WIDTH 16

// Exponent field width in bits
`define POSIT_ES 1

// Regime run length field width
// Wide enough to hold a run of POSIT_WIDTH-1 bits
`define POSIT_RS ($clog2(`POSIT_WIDTH))

// Enabled cycles from operand capture to result
`define POSIT_MUL_LATENCY 13

`endif

// File: source/posit_fields_if.sv
// ==================================================
// Decoded fields of one posit operand
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface posit_fields_if;

  // Operand sign bit
  logic                   sgn;
  // Regime sign, high for a run of ones
  logic                   rgs;
  // Regime magnitude as seen by the decoder
  posit_fmt_pkg::regime_t rgm;
  posit_fmt_pkg::exp_t    exp;
  posit_fmt_pkg::sig_t    sig;
  // Special value flags
  logic                   zer;
  logic                   inf;

  // Decoder side writes every field
  modport decoder (output sgn, rgs, rgm, exp, sig, zer, inf);

  // Multiplier side only reads
  modport consumer (input sgn, rgs, rgm, exp, sig, zer, inf);

endinterface

`default_nettype wire

// File: source/posit_fmt_pkg.sv
// ==================================================
// Number format types of a posit word and its fields
// Widths come from the shared posit macros
// ==================================================
`default_nettype none

`include "posit_defines.svh"

package posit_fmt_pkg;

  // Full posit word in two's complement form
  typedef logic [`POSIT_WIDTH-1:0] posit_t;

  // Length of the leading regime run
  typedef logic [`POSIT_RS-1:0] regime_t;

  // Exponent field
  typedef logic [`POSIT_ES-1:0] exp_t;

  // Significand with hidden bit at the top
  // Fraction bits follow the hidden bit
  typedef logic [`POSIT_WIDTH-`POSIT_ES-1:0] sig_t;

endpackage

`default_nettype wire

// File: source/posit_mul_unit.sv
// ==================================================
// Posit multiplier top, result 13 enabled cycles on
// Pipeline holds while ce is low
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module posit_mul_unit (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        ce,
  input  wire posit_fmt_pkg::posit_t a,
  input  wire posit_fmt_pkg::posit_t b,
  output posit_fmt_pkg::posit_t      o,
  output logic                       zero,
  output logic                       inf
);

  // Output registers and their reset live in the pipeline
  posit_multiply mul_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ce     (ce),
    .a      (a),
    .b      (b),
    .o      (o),
    .zero   (zero),
    .inf    (inf)
  );

endmodule

`default_nettype wire

// File: source/posit_multiply.sv
// ==================================================
// Posit multiplier, 13 enabled cycles, RNE rounding
// Saturates at maxpos and minpos, never rounds to 0
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "posit_defines.svh"

module posit_multiply (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        ce,
  input  wire posit_fmt_pkg::posit_t a,
  input  wire posit_fmt_pkg::posit_t b,
  output posit_fmt_pkg::posit_t      o,
  output logic                       zero,
  output logic                       inf
);

  localparam int N   = `POSIT_WIDTH;
  localparam int ES  = `POSIT_ES;
  localparam int RS  = `POSIT_RS;
  localparam int SW  = N - ES;
  localparam int PW  = 2 * SW;
  // Signed regime and run length width
  localparam int KW  = RS + 2;
  localparam int SCW = RS + ES + 2;
  // Run, terminator, exponent, fraction and zero padding
  localparam int XW  = 2 + ES + (PW - 1) + N;
  localparam int SIGN_DEPTH = `POSIT_MUL_LATENCY - 4;
  localparam int FLAG_DEPTH = `POSIT_MUL_LATENCY - 3;

  // ==================================================
  // Stage 1, operand decode
  // ==================================================
  posit_fields_if fa ();
  posit_fields_if fb ();

  posit_decompose_reg dec_a_i (
    .clk (clk),
    .ce  (ce),
    .i   (a),
    .f   (fa)
  );

  posit_decompose_reg dec_b_i (
    .clk (clk),
    .ce  (ce),
    .i   (b),
    .f   (fb)
  );

  // ==================================================
  // Stages 2 to 5, product and scale
  // ==================================================
  logic signed [KW-1:0]   ka;
  logic signed [KW-1:0]   kb;
  posit_pipe_pkg::prod_t  prod2;
  posit_pipe_pkg::scale_t sc_a2;
  posit_pipe_pkg::scale_t sc_b2;
  logic                   so2;
  logic                   zero2;
  logic                   inf2;

  // Signed regime value of each operand
  assign ka = fa.rgs ? $signed({2'b00, fa.rgm}) : -$signed({2'b00, fa.rgm});
  assign kb = fb.rgs ? $signed({2'b00, fb.rgm}) : -$signed({2'b00, fb.rgm});

  always_ff @(posedge clk) begin
    if (ce) begin
      prod2 <= fa.sig * fb.sig;
      sc_a2 <= {ka, fa.exp};
      sc_b2 <= {kb, fb.exp};
      so2   <= fa.sgn ^ fb.sgn;
      inf2  <= fa.inf | fb.inf;
      // NaR wins over zero
      zero2 <= (fa.zer | fb.zer) & ~(fa.inf | fb.inf);
    end
  end

  logic                   mo;
  posit_pipe_pkg::prod_t  prod3;
  posit_pipe_pkg::scale_t scale3;

  // Product in [2,4) carries one more power of two
  assign mo = prod2[PW-1];

  always_ff @(posedge clk) begin
    if (ce) begin
      prod3  <= mo ? prod2 : {prod2[PW-2:0], 1'b0};
      scale3 <= sc_a2 + sc_b2 + {{(SCW-1){1'b0}}, mo};
    end
  end

  logic signed [KW-1:0] k3;
  logic [KW-1:0]        kmag4;
  posit_fmt_pkg::exp_t  e4;
  logic                 neg4;
  logic [PW-2:0]        frac4;

  // Upper scale bits hold the result regime
  assign k3 = scale3[SCW-1:ES];

  always_ff @(posedge clk) begin
    if (ce) begin
      kmag4 <= scale3[SCW-1] ? -k3 : k3;
      e4    <= scale3[ES-1:0];
      neg4  <= scale3[SCW-1];
      // Hidden bit dropped
      frac4 <= prod3[PW-2:0];
    end
  end

  logic [KW-1:0] run_c;
  logic          sat_c;
  logic [KW-1:0] sh5;
  logic [1:0]    sn5;
  logic [XW-1:0] x5;

  // Ones run is one longer than a positive regime
  assign run_c = neg4 ? kmag4 : kmag4 + 1'b1;
  // Regime alone fills the body
  assign sat_c = (run_c >= N - 1);

  always_ff @(posedge clk) begin
    if (ce) begin
      sh5 <= sat_c ? '0 : run_c - 1'b1;
      sn5 <= {sat_c, neg4};
      x5  <= {~neg4, neg4, e4, frac4, {N{1'b0}}};
    end
  end

  // ==================================================
  // Stages 6 to 11, regime shift and rounding
  // ==================================================
  logic signed [XW-1:0] x6;
  logic [1:0]           sh6;
  logic [1:0]           sn6;
  logic signed [XW-1:0] x7;
  logic [1:0]           sn7;

  // Arithmetic shift replicates the run bit, coarse then fine
  always_ff @(posedge clk) begin
    if (ce) begin
      x6  <= $signed(x5) >>> {sh5[KW-1:2], 2'b00};
      sh6 <= sh5[1:0];
      sn6 <= sn5;
      x7  <= x6 >>> sh6;
      sn7 <= sn6;
    end
  end

  logic [N-2:0]                body8;
  posit_pipe_pkg::round_bits_t rb8;
  logic [1:0]                  sn8;
  logic [N-2:0]                body9;
  logic                        ulp9;
  logic [1:0]                  sn9;
  logic [N-2:0]                rnd10;
  logic [1:0]                  sn10;
  logic [N-2:0]                mag11;

  always_ff @(posedge clk) begin
    if (ce) begin
      // Top N-1 bits form the unsigned posit body
      body8 <= x7[XW-1 -: N-1];
      rb8   <= {x7[XW-N+1], x7[XW-N], x7[XW-N-1], |x7[XW-N-2:0]};
      sn8   <= sn7;
      // Nearest even
      ulp9  <= rb8[2] & (rb8[3] | rb8[1] | rb8[0]);
      body9 <= body8;
      sn9   <= sn8;
      rnd10 <= body9 + {{(N-2){1'b0}}, ulp9};
      sn10  <= sn9;
      // Saturated results skip rounding
      if (sn10[1]) begin
        mag11 <= sn10[0] ? {{(N-2){1'b0}}, 1'b1} : {(N-1){1'b1}};
      end else begin
        mag11 <= rnd10;
      end
    end
  end

  // ==================================================
  // Stages 12 and 13, sign and special values
  // ==================================================
  logic                  so11;
  logic                  zero12;
  logic                  inf12;
  posit_fmt_pkg::posit_t res12;

  delay_line #(.WIDTH(1), .DEPTH(SIGN_DEPTH)) sign_dly_i (
    .clk (clk),
    .ce  (ce),
    .i   (so2),
    .o   (so11)
  );

  delay_line #(.WIDTH(1), .DEPTH(FLAG_DEPTH)) zero_dly_i (
    .clk (clk),
    .ce  (ce),
    .i   (zero2),
    .o   (zero12)
  );

  delay_line #(.WIDTH(1), .DEPTH(FLAG_DEPTH)) inf_dly_i (
    .clk (clk),
    .ce  (ce),
    .i   (inf2),
    .o   (inf12)
  );

  // Negative results in two's complement
  always_ff @(posedge clk) begin
    if (ce) begin
      res12 <= so11 ? -{1'b0, mag11} : {1'b0, mag11};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      o    <= '0;
      zero <= 1'b0;
      inf  <= 1'b0;
    end else if (ce) begin
      zero <= zero12;
      inf  <= inf12;
      if (inf12) begin
        o <= {1'b1, {(N-1){1'b0}}};
      end else if (zero12) begin
        o <= '0;
      end else begin
        o <= res12;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/posit_pipe_pkg.sv
// ==================================================
// Types used only inside the multiplier pipeline
// ==================================================
`default_nettype none

`include "posit_defines.svh"

package posit_pipe_pkg;

  // Raw significand product with two integer bits
  typedef logic [2*$bits(posit_fmt_pkg::sig_t)-1:0] prod_t;

  // Signed scale as regime times 2^ES plus exponent
  // Two spare bits cover the sum of both operands
  typedef logic signed [`POSIT_RS+`POSIT_ES+1:0] scale_t;

  // Rounding bits ordered lsb, guard, round, sticky
  typedef logic [3:0] round_bits_t;

endpackage

`default_nettype wire

// File: test/posit_mul_stim.txt
// Columns in hex: a b expected_o expected_zero expected_inf ce
// Posit 16 bits, es 1; ce 0 lines are idle cycles
4000 5800 5800 0 0 1
5000 3000 4000 0 0 1
6000 2000 4000 0 0 1
7000 7000 7c00 0 0 1
2000 2000 1000 0 0 1
5000 5000 6000 0 0 1
4800 4800 5200 0 0 1
5800 5800 6900 0 0 1
0000 0000 0000 0 0 0
0000 4000 0000 1 0 1
5800 0000 0000 1 0 1
0000 0000 0000 1 0 1
8000 4000 8000 0 1 1
8000 0000 8000 0 1 1
0000 8000 8000 0 1 1
c000 5000 b000 0 0 1
c000 c000 4000 0 0 1
4800 b000 a800 0 0 1
d000 d000 2000 0 0 1
b800 4800 ae00 0 0 1
0000 0000 0000 0 0 0
4001 4001 4002 0 0 1
4001 4800 4802 0 0 1
4003 4800 4804 0 0 1
7fff 7fff 7fff 0 0 1
7fff 5000 7fff 0 0 1
0001 0001 0001 0 0 1
0001 3000 0001 0 0 1
8001 7fff 8001 0 0 1
7fff 0001 4000 0 0 1
0001 8001 c000 0 0 1

// File: test/posit_mul_unit_checker.sv
// ==================================================
// Output encoding assertions, bound to the top level
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module posit_mul_unit_checker (
  input wire                        clk,
  input wire                        arst_n,
  input wire posit_fmt_pkg::posit_t o,
  input wire                        zero,
  input wire                        inf
);

  localparam int N = $bits(posit_fmt_pkg::posit_t);

  // Failed assertions so far, read by the testbench
  int unsigned fail_count = 0;

  // Zero and NaR are exclusive
  flags_exclusive_a : assert property (
    @(posedge clk) disable iff (!arst_n) !(zero && inf)
  ) else begin
    fail_count++;
    $error("zero and inf are high together");
  end

  // Zero flag means an all-zero word
  zero_word_a : assert property (
    @(posedge clk) disable iff (!arst_n) zero |-> (o == '0)
  ) else begin
    fail_count++;
    $error("zero is high but o is %h", o);
  end

  // NaR is the sign bit alone
  nar_word_a : assert property (
    @(posedge clk) disable iff (!arst_n) inf |-> (o == {1'b1, {(N-1){1'b0}}})
  ) else begin
    fail_count++;
    $error("inf is high but o is %h", o);
  end

endmodule

`default_nettype wire

// File: test/posit_mul_unit_tb.sv
// ==================================================
// Testbench for the posit multiplier, vectors from file
// Results are matched by counting enabled cycles
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "posit_defines.svh"

module posit_mul_unit_tb;

  localparam int LAT      = `POSIT_MUL_LATENCY;
  localparam int MAX_VEC  = 64;
  localparam int MAX_IDLE = 3;
  localparam int MARGIN   = 20;
  localparam int RST_CYC  = 5;

  logic                  clk;
  logic                  arst_n;
  logic                  ce;
  posit_fmt_pkg::posit_t a;
  posit_fmt_pkg::posit_t b;
  posit_fmt_pkg::posit_t o;
  logic                  zero;
  logic                  inf;

  // Vector storage read from the stimulus file
  posit_fmt_pkg::posit_t vec_a [MAX_VEC];
  posit_fmt_pkg::posit_t vec_b [MAX_VEC];
  posit_fmt_pkg::posit_t vec_o [MAX_VEC];
  logic                  vec_z [MAX_VEC];
  logic                  vec_i [MAX_VEC];
  logic                  vec_ce [MAX_VEC];
  int                    nvec;

  // Expected values travel with the operands
  logic                  valid_in;
  posit_fmt_pkg::posit_t exp_o_in;
  logic                  exp_z_in;
  logic                  exp_i_in;

  // Results in flight, tagged by capture edge
  posit_fmt_pkg::posit_t q_o [$];
  logic                  q_z [$];
  logic                  q_i [$];
  int                    q_tag [$];

  int                    en_count;
  logic                  last_en;
  posit_fmt_pkg::posit_t prev_o;
  logic                  prev_zero;
  logic                  prev_inf;
  int                    cycles;
  int                    cycle_limit;

  posit_mul_unit dut_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ce     (ce),
    .a      (a),
    .b      (b),
    .o      (o),
    .zero   (zero),
    .inf    (inf)
  );

  bind posit_mul_unit posit_mul_unit_checker checker_i (
    .clk    (clk),
    .arst_n (arst_n),
    .o      (o),
    .zero   (zero),
    .inf    (inf)
  );

  // ==================================================
  // Clock, cycle limit and compare tasks
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: results still pending after %0d cycles", cycles);
      $display("Test failures found");
      $fatal(1, "run stopped on cycle limit");
    end
  end

  // Bound assertions count their own failures
  always @(negedge clk) begin
    if (dut_i.checker_i.fail_count != 0) begin
      $display("Output encoding assertion failed at %0t", $time);
      $display("Test failures found");
      $fatal(1, "assertion failure");
    end
  end

  task automatic check_posit(input string name, input posit_fmt_pkg::posit_t expected,
                             input posit_fmt_pkg::posit_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1, "flag mismatch");
    end
  endtask

  // ==================================================
  // Result tracking
  // ==================================================

  // Inputs are NBA driven, so these reads see the captured values
  always @(posedge clk) begin
    if (arst_n) begin
      last_en = ce;
      if (ce) begin
        en_count = en_count + 1;
        if (valid_in) begin
          q_o.push_back(exp_o_in);
          q_z.push_back(exp_z_in);
          q_i.push_back(exp_i_in);
          q_tag.push_back(en_count);
        end
      end
    end else begin
      last_en = 1'b0;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (last_en) begin
        if (q_tag.size() > 0 && q_tag[0] == en_count - (LAT - 1)) begin
          check_posit("o", q_o[0], o);
          check_flag("zero", q_z[0], zero);
          check_flag("inf", q_i[0], inf);
          void'(q_o.pop_front());
          void'(q_z.pop_front());
          void'(q_i.pop_front());
          void'(q_tag.pop_front());
        end
      end else begin
        // Stalled pipeline keeps its outputs
        check_posit("o during stall", prev_o, o);
        check_flag("zero during stall", prev_zero, zero);
        check_flag("inf during stall", prev_inf, inf);
      end
      prev_o    = o;
      prev_zero = zero;
      prev_inf  = inf;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic read_vectors();
    int                    fd;
    int                    n;
    string                 line;
    posit_fmt_pkg::posit_t ta;
    posit_fmt_pkg::posit_t tb;
    posit_fmt_pkg::posit_t to;
    logic                  tz;
    logic                  ti;
    logic                  tce;
    fd = $fopen("test/posit_mul_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/posit_mul_stim.txt");
      $display("Test failures found");
      $fatal(1, "missing stimulus");
    end
    nvec = 0;
    while ($fgets(line, fd) != 0) begin
      // Comment lines yield no fields
      n = $sscanf(line, "%h %h %h %h %h %h", ta, tb, to, tz, ti, tce);
      if (n == 6 && nvec < MAX_VEC) begin
        vec_a[nvec]  = ta;
        vec_b[nvec]  = tb;
        vec_o[nvec]  = to;
        vec_z[nvec]  = tz;
        vec_i[nvec]  = ti;
        vec_ce[nvec] = tce;
        nvec++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int idle;
    void'($urandom(32'h4302_edb1));
    arst_n      = 1'b0;
    ce          = 1'b0;
    a           = '0;
    b           = '0;
    valid_in    = 1'b0;
    exp_o_in    = '0;
    exp_z_in    = 1'b0;
    exp_i_in    = 1'b0;
    en_count    = 0;
    last_en     = 1'b0;
    prev_o      = '0;
    prev_zero   = 1'b0;
    prev_inf    = 1'b0;
    cycles      = 0;
    cycle_limit = 1000;
    read_vectors();
    // Reset, worst case idles per vector, drain and margin
    cycle_limit = RST_CYC + nvec * (1 + MAX_IDLE) + LAT + MARGIN;

    repeat (RST_CYC) @(posedge clk);
    arst_n <= 1'b1;

    for (int v = 0; v < nvec; v++) begin
      @(posedge clk);
      a        <= vec_a[v];
      b        <= vec_b[v];
      ce       <= vec_ce[v];
      valid_in <= vec_ce[v];
      exp_o_in <= vec_o[v];
      exp_z_in <= vec_z[v];
      exp_i_in <= vec_i[v];
      // Random stall between vectors
      idle = $urandom % (MAX_IDLE + 1);
      repeat (idle) begin
        @(posedge clk);
        ce       <= 1'b0;
        valid_in <= 1'b0;
        a        <= posit_fmt_pkg::posit_t'($urandom);
        b        <= posit_fmt_pkg::posit_t'($urandom);
      end
    end

    // Flush the pipeline with untracked operands
    @(posedge clk);
    ce       <= 1'b1;
    valid_in <= 1'b0;
    a        <= '0;
    b        <= '0;
    @(posedge clk);
    while (q_tag.size() > 0) begin
      @(posedge clk);
    end
    @(negedge clk);

    if (dut_i.checker_i.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
